// File: rtl/gb_media_pkg.sv
// Game console storage control, shared definitions
// Download kinds, backup sequencer states, the 16-bit word type
// and the default widths used by the backup and cheat blocks

package gb_media_pkg;

	////////////////////////////////////////////////////////////
	// Widths

	// Low part of the block address compared against the RAM mask
	localparam int DEF_BLOCK_IDX_W = 8;

	// Word address inside one SD buffer
	localparam int DEF_BUF_ADDR_W = 8;

	// Flags, address, compare and replace are all this wide
	localparam int CHEAT_FIELD_W = 32;

	////////////////////////////////////////////////////////////
	// Types

	// One download word or SD buffer word
	typedef logic [15:0] word_t;

	// What the host is sending on the download port
	typedef enum logic [2:0] {
		DL_NONE,
		DL_CART,
		DL_PALETTE,
		DL_BIOS,
		DL_BORDER,
		DL_CODE
	} dl_kind_e;

	// Backup RAM transfer in progress
	typedef enum logic [1:0] {
		BK_IDLE,
		BK_LOAD,
		BK_SAVE
	} bk_state_e;

endpackage

// File: rtl/download_decode.sv
// Download decoder
// Maps the host download index to a download kind, makes the
// end-of-cart-download pulse and keeps the backup enable flag

`timescale 1ns/1ps

module download_decode (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       ioctl_download,
	input  logic [7:0] ioctl_index,
	input  logic       img_mounted,
	input  logic       img_readonly,
	output logic       cart_download,
	output logic       palette_download,
	output logic       code_download,
	output logic       cart_done,
	output logic       bk_ena
);
	import gb_media_pkg::*;

	dl_kind_e dl_kind;
	logic     cart_dl_q;

	// Index decode, only valid while a download runs
	always_comb begin
		dl_kind = DL_NONE;
		if (ioctl_download) begin
			case (ioctl_index)
				8'h01, 8'h41, 8'h80: dl_kind = DL_CART;
				8'h03:               dl_kind = DL_PALETTE;
				8'h40:               dl_kind = DL_BIOS;
				8'h02:               dl_kind = DL_BORDER;
				8'hFF:               dl_kind = DL_CODE;
				default:             dl_kind = DL_NONE;
			endcase
		end
	end

	assign cart_download    = (dl_kind == DL_CART);
	assign palette_download = (dl_kind == DL_PALETTE);
	assign code_download    = (dl_kind == DL_CODE);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_dl_q <= 1'b0;
			cart_done <= 1'b0;
			bk_ena    <= 1'b0;
		end else begin
			cart_dl_q <= cart_download;
			// One cycle after the first low cycle of cart_download
			cart_done <= cart_dl_q & ~cart_download;

			// New cartridge drops the old backup enable
			if (~cart_dl_q & cart_download)
				bk_ena <= 1'b0;
			// Save image gets mounted while the cart is coming in
			if (cart_download & img_mounted & ~img_readonly)
				bk_ena <= 1'b1;
		end
	end

endmodule

// File: rtl/cheat_code_loader.sv
// Cheat code loader
// Builds one code from eight 16-bit download words and pulses it
// out to the cheat engine, and raises the list clear pulse

`timescale 1ns/1ps

module cheat_code_loader (
	input  logic                                  clk_sys,
	input  logic                                  reset,
	input  logic                                  code_download,
	input  logic                                  cart_download,
	input  logic                                  palette_download,
	input  logic                                  ioctl_wr,
	input  logic [24:0]                           ioctl_addr,
	input  gb_media_pkg::word_t                   ioctl_dout,
	output logic                                  cheat_clear,
	output logic                                  cheat_valid,
	output logic [gb_media_pkg::CHEAT_FIELD_W-1:0] cheat_flags,
	output logic [gb_media_pkg::CHEAT_FIELD_W-1:0] cheat_addr,
	output logic [gb_media_pkg::CHEAT_FIELD_W-1:0] cheat_compare,
	output logic [gb_media_pkg::CHEAT_FIELD_W-1:0] cheat_replace
);
	import gb_media_pkg::*;

	localparam int HALF_W = CHEAT_FIELD_W / 2;

	logic code_wr;

	assign code_wr = code_download & ioctl_wr;

	// Byte offset within the 16-byte code picks the field half
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (ioctl_addr[3:0])
				4'd0:  cheat_flags[HALF_W-1:0]               <= ioctl_dout;
				4'd2:  cheat_flags[CHEAT_FIELD_W-1:HALF_W]   <= ioctl_dout;
				4'd4:  cheat_addr[HALF_W-1:0]                <= ioctl_dout;
				4'd6:  cheat_addr[CHEAT_FIELD_W-1:HALF_W]    <= ioctl_dout;
				4'd8:  cheat_compare[HALF_W-1:0]             <= ioctl_dout;
				4'd10: cheat_compare[CHEAT_FIELD_W-1:HALF_W] <= ioctl_dout;
				4'd12: cheat_replace[HALF_W-1:0]             <= ioctl_dout;
				4'd14: cheat_replace[CHEAT_FIELD_W-1:HALF_W] <= ioctl_dout;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cheat_valid <= 1'b0;
			cheat_clear <= 1'b0;
		end else begin
			// Last word of a code
			cheat_valid <= code_wr & (ioctl_addr[3:0] == 4'd14);
			// Palette downloads also empty the list
			cheat_clear <= (code_wr & (ioctl_addr == 25'd0)) | cart_download | palette_download;
		end
	end

endmodule

// File: rtl/backup_sequencer.sv
// Backup RAM sequencer
// Steps through SD block requests to load or save cartridge RAM,
// plus one trailing clock block when the cartridge has an RTC.
// Also tracks the autosave pending flag

`timescale 1ns/1ps

module backup_sequencer #(
	parameter int BLOCK_IDX_W = gb_media_pkg::DEF_BLOCK_IDX_W
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   cart_done,
	input  logic                   bk_ena,
	input  logic                   img_size_nonzero,
	input  logic                   load_req,
	input  logic                   save_req,
	input  logic                   autosave_en,
	input  logic                   osd_open,
	input  logic                   cram_wr,
	input  logic                   has_save,
	input  logic                   rtc_inuse,
	input  logic [BLOCK_IDX_W-1:0] ram_mask,
	input  logic                   sd_ack,
	output logic [31:0]            sd_lba,
	output logic                   sd_rd,
	output logic                   sd_wr,
	output logic                   bk_loading,
	output logic                   save_pending
);
	import gb_media_pkg::*;

	bk_state_e              state;
	logic                   load_req_q;
	logic                   save_req_q;
	logic                   autosave_q;
	logic                   ack_q;
	logic                   autosave;
	logic                   ack_rise;
	logic                   ack_fall;
	logic                   load_start;
	logic                   save_start;
	logic                   last_block;
	logic [BLOCK_IDX_W-1:0] blk_idx;

	////////////////////////////////////////////////////////////
	// Start and block-end detection

	assign autosave = save_pending & osd_open & autosave_en;
	assign ack_rise = sd_ack & ~ack_q;
	assign ack_fall = ~sd_ack & ack_q;

	// Load wins when both sides fire together
	assign load_start = (cart_done & img_size_nonzero & bk_ena) |
	                    (bk_ena & load_req & ~load_req_q);
	assign save_start = bk_ena & ~load_start &
	                    ((save_req & ~save_req_q) | (autosave & ~autosave_q));

	assign blk_idx = sd_lba[BLOCK_IDX_W-1:0];
	// RTC adds one block past the mask
	assign last_block = rtc_inuse ? (blk_idx > ram_mask) : (blk_idx >= ram_mask);

	assign bk_loading = (state == BK_LOAD);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			load_req_q <= 1'b0;
			save_req_q <= 1'b0;
			autosave_q <= 1'b0;
			ack_q      <= 1'b0;
		end else begin
			load_req_q <= load_req;
			save_req_q <= save_req;
			autosave_q <= autosave;
			ack_q      <= sd_ack;
		end
	end

	////////////////////////////////////////////////////////////
	// Block FSM

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state  <= BK_IDLE;
			sd_lba <= '0;
			sd_rd  <= 1'b0;
			sd_wr  <= 1'b0;
		end else begin
			// Host has seen the request
			if (ack_rise) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			case (state)
				BK_IDLE: begin
					if (load_start) begin
						state  <= BK_LOAD;
						sd_lba <= '0;
						sd_rd  <= 1'b1;
						sd_wr  <= 1'b0;
					end else if (save_start) begin
						state  <= BK_SAVE;
						sd_lba <= '0;
						sd_rd  <= 1'b0;
						sd_wr  <= 1'b1;
					end
				end
				BK_LOAD, BK_SAVE: begin
					if (ack_fall) begin
						if (last_block) begin
							state <= BK_IDLE;
						end else begin
							sd_lba <= sd_lba + 32'd1;
							sd_rd  <= (state == BK_LOAD);
							sd_wr  <= (state == BK_SAVE);
						end
					end
				end
				default: state <= BK_IDLE;
			endcase
		end
	end

	// Game wrote cart RAM while playing
	always_ff @(posedge clk_sys) begin
		if (reset)
			save_pending <= 1'b0;
		else if ((state == BK_IDLE) & (load_start | save_start))
			save_pending <= 1'b0;
		else if (cram_wr & ~osd_open & has_save & bk_ena)
			save_pending <= 1'b1;
	end

endmodule

// File: rtl/backup_data_path.sv
// Backup data path
// Forms the backup RAM address and write strobes from the SD buffer
// side, and picks RAM data or RTC words for the host on saves

`timescale 1ns/1ps

module backup_data_path #(
	parameter int BLOCK_IDX_W = gb_media_pkg::DEF_BLOCK_IDX_W,
	parameter int BUF_ADDR_W  = gb_media_pkg::DEF_BUF_ADDR_W
) (
	input  logic [31:0]                       sd_lba,
	input  logic [BUF_ADDR_W-1:0]             sd_buff_addr,
	input  gb_media_pkg::word_t               sd_buff_dout,
	input  logic                              sd_buff_wr,
	input  logic                              sd_ack,
	input  logic [BLOCK_IDX_W-1:0]            ram_mask,
	input  gb_media_pkg::word_t               bk_q,
	input  logic [31:0]                       rtc_timestamp,
	input  logic [31:0]                       rtc_savedtime,
	output logic [BLOCK_IDX_W+BUF_ADDR_W-1:0] bk_addr,
	output gb_media_pkg::word_t               bk_data,
	output logic                              bk_wr,
	output logic                              bk_rtc_wr,
	output gb_media_pkg::word_t               sd_buff_din
);

	logic [BLOCK_IDX_W-1:0] blk_idx;
	logic                   data_blk;

	assign blk_idx  = sd_lba[BLOCK_IDX_W-1:0];
	// Anything past the mask is the clock block
	assign data_blk = (blk_idx <= ram_mask);

	assign bk_addr   = {blk_idx, sd_buff_addr};
	assign bk_data   = sd_buff_dout;
	assign bk_wr     = sd_buff_wr & sd_ack & data_blk;
	assign bk_rtc_wr = sd_buff_wr & sd_ack & ~data_blk;

	always_comb begin
		if (data_blk) begin
			sd_buff_din = bk_q;
		end else begin
			case (sd_buff_addr)
				0:       sd_buff_din = rtc_timestamp[15:0];
				1:       sd_buff_din = rtc_timestamp[31:16];
				2:       sd_buff_din = rtc_savedtime[15:0];
				3:       sd_buff_din = rtc_savedtime[31:16];
				default: sd_buff_din = '1;
			endcase
		end
	end

endmodule

// File: rtl/gb_media_ctrl.sv
// Storage-side control of the console core
// Download decoding, cheat code assembly and backup RAM load/save
// over the SD block handshake

`timescale 1ns/1ps

module gb_media_ctrl #(
	parameter int BLOCK_IDX_W = gb_media_pkg::DEF_BLOCK_IDX_W,
	parameter int BUF_ADDR_W  = gb_media_pkg::DEF_BUF_ADDR_W
) (
	input  logic                                   clk_sys,
	input  logic                                   reset,
	// Host download port
	input  logic                                   ioctl_download,
	input  logic [7:0]                             ioctl_index,
	input  logic                                   ioctl_wr,
	input  logic [24:0]                            ioctl_addr,
	input  gb_media_pkg::word_t                    ioctl_dout,
	// SD block handshake
	output logic [31:0]                            sd_lba,
	output logic                                   sd_rd,
	output logic                                   sd_wr,
	input  logic                                   sd_ack,
	input  logic [BUF_ADDR_W-1:0]                  sd_buff_addr,
	input  gb_media_pkg::word_t                    sd_buff_dout,
	input  logic                                   sd_buff_wr,
	output gb_media_pkg::word_t                    sd_buff_din,
	input  logic                                   img_mounted,
	input  logic                                   img_readonly,
	input  logic                                   img_size_nonzero,
	// Cartridge side
	input  logic [BLOCK_IDX_W-1:0]                 ram_mask,
	input  logic                                   rtc_inuse,
	input  logic                                   has_save,
	input  logic                                   cram_wr,
	input  gb_media_pkg::word_t                    bk_q,
	input  logic [31:0]                            rtc_timestamp,
	input  logic [31:0]                            rtc_savedtime,
	output logic [BLOCK_IDX_W+BUF_ADDR_W-1:0]      bk_addr,
	output gb_media_pkg::word_t                    bk_data,
	output logic                                   bk_wr,
	output logic                                   bk_rtc_wr,
	output logic                                   bk_loading,
	output logic                                   save_pending,
	// Options
	input  logic                                   load_req,
	input  logic                                   save_req,
	input  logic                                   autosave_en,
	input  logic                                   osd_open,
	// Cheat engine
	output logic                                   cheat_clear,
	output logic                                   cheat_valid,
	output logic [gb_media_pkg::CHEAT_FIELD_W-1:0] cheat_flags,
	output logic [gb_media_pkg::CHEAT_FIELD_W-1:0] cheat_addr,
	output logic [gb_media_pkg::CHEAT_FIELD_W-1:0] cheat_compare,
	output logic [gb_media_pkg::CHEAT_FIELD_W-1:0] cheat_replace
);

	logic cart_download;
	logic palette_download;
	logic code_download;
	logic cart_done;
	logic bk_ena;

	////////////////////////////////////////////////////////////
	// Decode

	download_decode u_download_decode (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.ioctl_download   (ioctl_download),
		.ioctl_index      (ioctl_index),
		.img_mounted      (img_mounted),
		.img_readonly     (img_readonly),
		.cart_download    (cart_download),
		.palette_download (palette_download),
		.code_download    (code_download),
		.cart_done        (cart_done),
		.bk_ena           (bk_ena)
	);

	////////////////////////////////////////////////////////////
	// Execute

	cheat_code_loader u_cheat_code_loader (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.code_download    (code_download),
		.cart_download    (cart_download),
		.palette_download (palette_download),
		.ioctl_wr         (ioctl_wr),
		.ioctl_addr       (ioctl_addr),
		.ioctl_dout       (ioctl_dout),
		.cheat_clear      (cheat_clear),
		.cheat_valid      (cheat_valid),
		.cheat_flags      (cheat_flags),
		.cheat_addr       (cheat_addr),
		.cheat_compare    (cheat_compare),
		.cheat_replace    (cheat_replace)
	);

	backup_sequencer #(
		.BLOCK_IDX_W (BLOCK_IDX_W)
	) u_backup_sequencer (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.cart_done        (cart_done),
		.bk_ena           (bk_ena),
		.img_size_nonzero (img_size_nonzero),
		.load_req         (load_req),
		.save_req         (save_req),
		.autosave_en      (autosave_en),
		.osd_open         (osd_open),
		.cram_wr          (cram_wr),
		.has_save         (has_save),
		.rtc_inuse        (rtc_inuse),
		.ram_mask         (ram_mask),
		.sd_ack           (sd_ack),
		.sd_lba           (sd_lba),
		.sd_rd            (sd_rd),
		.sd_wr            (sd_wr),
		.bk_loading       (bk_loading),
		.save_pending     (save_pending)
	);

	////////////////////////////////////////////////////////////
	// Result

	backup_data_path #(
		.BLOCK_IDX_W (BLOCK_IDX_W),
		.BUF_ADDR_W  (BUF_ADDR_W)
	) u_backup_data_path (
		.sd_lba        (sd_lba),
		.sd_buff_addr  (sd_buff_addr),
		.sd_buff_dout  (sd_buff_dout),
		.sd_buff_wr    (sd_buff_wr),
		.sd_ack        (sd_ack),
		.ram_mask      (ram_mask),
		.bk_q          (bk_q),
		.rtc_timestamp (rtc_timestamp),
		.rtc_savedtime (rtc_savedtime),
		.bk_addr       (bk_addr),
		.bk_data       (bk_data),
		.bk_wr         (bk_wr),
		.bk_rtc_wr     (bk_rtc_wr),
		.sd_buff_din   (sd_buff_din)
	);

endmodule

// File: test/sd_host_model.sv
// SD host model
// Answers block read and write requests after a random gap, holds
// sd_ack for one full buffer of words and logs every block address

`timescale 1ns/1ps

module sd_host_model #(
	parameter int BUF_ADDR_W = 8,
	parameter int GAP_MAX    = 8
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic [31:0]           noise,
	input  logic [31:0]           sd_lba,
	input  logic                  sd_rd,
	input  logic                  sd_wr,
	output logic                  sd_ack,
	output logic [BUF_ADDR_W-1:0] sd_buff_addr,
	output logic [15:0]           sd_buff_dout,
	output logic                  sd_buff_wr
);
	int          gap;
	logic        busy;
	logic        reading;
	int          blocks;
	int          rd_blocks;
	int          wr_blocks;
	logic [31:0] lba_log [0:63];

	initial begin
		sd_ack       = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		sd_buff_wr   = 1'b0;
	end

	// Host side changes on the falling edge, like the rest of the stimulus
	always @(negedge clk_sys) begin
		if (reset) begin
			sd_ack       <= 1'b0;
			sd_buff_addr <= '0;
			sd_buff_wr   <= 1'b0;
			busy         <= 1'b0;
			gap          <= 0;
			blocks       <= 0;
			rd_blocks    <= 0;
			wr_blocks    <= 0;
		end else if (sd_ack) begin
			if (&sd_buff_addr) begin
				// Last word done, falling ack ends the block
				sd_ack     <= 1'b0;
				sd_buff_wr <= 1'b0;
				busy       <= 1'b0;
				blocks     <= blocks + 1;
				if (reading)
					rd_blocks <= rd_blocks + 1;
				else
					wr_blocks <= wr_blocks + 1;
			end else begin
				sd_buff_addr <= sd_buff_addr + 1'b1;
				sd_buff_dout <= noise[15:0];
			end
		end else if (busy) begin
			if (gap == 0) begin
				sd_ack       <= 1'b1;
				sd_buff_addr <= '0;
				sd_buff_wr   <= reading;
				sd_buff_dout <= noise[15:0];
			end else begin
				gap <= gap - 1;
			end
		end else if (sd_rd || sd_wr) begin
			busy               <= 1'b1;
			reading            <= sd_rd;
			gap                <= noise[7:0] % GAP_MAX;
			lba_log[blocks % 64] <= sd_lba;
		end
	end

endmodule

// File: test/gb_media_ctrl_tb.sv
// Testbench for the storage control top level
// Cheat assembly, backup load and save with and without the clock
// block, enable gating and autosave against a behavioral SD host

`timescale 1ns/1ps

module gb_media_ctrl_tb;
	import gb_media_pkg::*;

	localparam int IDX_W        = DEF_BLOCK_IDX_W;
	localparam int BUF_W        = DEF_BUF_ADDR_W;
	localparam int ADDR_W       = IDX_W + BUF_W;
	localparam int GAP_MAX      = 8;
	// Loads of 4 and 5 blocks, a 5 block save, a 4 block autosave
	localparam int TOTAL_BLOCKS = 18;
	// Gap, one buffer of words and the request turnaround
	localparam int BLOCK_MAX    = GAP_MAX + (1 << BUF_W) + 4;
	// Extra cycles cover the phases without SD traffic
	localparam int CYCLE_LIMIT  = (3 * TOTAL_BLOCKS * BLOCK_MAX) / 2 + 400;
	localparam logic [31:0] SEED = 32'd98;

	logic                             clk_sys;
	logic                             reset;
	logic                             ioctl_download;
	logic [7:0]                       ioctl_index;
	logic                             ioctl_wr;
	logic [24:0]                      ioctl_addr;
	word_t                            ioctl_dout;
	logic [31:0]                      sd_lba;
	logic                             sd_rd;
	logic                             sd_wr;
	logic                             sd_ack;
	logic [BUF_W-1:0]                 sd_buff_addr;
	word_t                            sd_buff_dout;
	logic                             sd_buff_wr;
	word_t                            sd_buff_din;
	logic                             img_mounted;
	logic                             img_readonly;
	logic                             img_size_nonzero;
	logic [IDX_W-1:0]                 ram_mask;
	logic                             rtc_inuse;
	logic                             has_save;
	logic                             cram_wr;
	word_t                            bk_q;
	logic [31:0]                      rtc_timestamp;
	logic [31:0]                      rtc_savedtime;
	logic [IDX_W+BUF_W-1:0]           bk_addr;
	word_t                            bk_data;
	logic                             bk_wr;
	logic                             bk_rtc_wr;
	logic                             bk_loading;
	logic                             save_pending;
	logic                             load_req;
	logic                             save_req;
	logic                             autosave_en;
	logic                             osd_open;
	logic                             cheat_clear;
	logic                             cheat_valid;
	logic [CHEAT_FIELD_W-1:0]         cheat_flags;
	logic [CHEAT_FIELD_W-1:0]         cheat_addr;
	logic [CHEAT_FIELD_W-1:0]         cheat_compare;
	logic [CHEAT_FIELD_W-1:0]         cheat_replace;

	logic [31:0] rng;
	logic [31:0] noise;
	logic [31:0] exp_field [0:3];
	logic        code_write;
	logic        cart_dl;
	logic        pal_dl;
	int          errors = 0;
	int          mark = 0;
	int          n_pass = 0;
	int          n_fail = 0;
	int          cycles = 0;
	int          valid_count = 0;
	int          rtc_wr_count = 0;
	int          bk_wr_count = 0;
	int          rd0;
	int          wr0;
	int          blk0;

	gb_media_ctrl #(
		.BLOCK_IDX_W (IDX_W),
		.BUF_ADDR_W  (BUF_W)
	) dut (.*);

	sd_host_model #(
		.BUF_ADDR_W (BUF_W),
		.GAP_MAX    (GAP_MAX)
	) host (.*);

	assign code_write = ioctl_download && (ioctl_index == 8'hFF) && ioctl_wr;
	assign cart_dl    = ioctl_download && (ioctl_index inside {8'h01, 8'h41, 8'h80});
	assign pal_dl     = ioctl_download && (ioctl_index == 8'h03);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Word the host should read: RAM data, or the clock block layout
	function automatic word_t expected_din(input logic [31:0] lba, input logic [BUF_W-1:0] a,
		input word_t q, input logic [31:0] ts, input logic [31:0] st);
		if (lba <= 32'(ram_mask))
			return q;
		case (a)
			0:       return ts[15:0];
			1:       return ts[31:16];
			2:       return st[15:0];
			3:       return st[31:16];
			default: return 16'hFFFF;
		endcase
	endfunction

	task automatic report_error(input string msg);
		errors++;
		$display("ERR %0t: %s", $time, msg);
	endtask

	task automatic end_test(input string name);
		if (errors == mark) begin
			n_pass++;
			$display("PASS %s", name);
		end else begin
			n_fail++;
			$display("FAIL %s", name);
		end
		mark = errors;
	endtask

	task automatic mark_host();
		rd0  = host.rd_blocks;
		wr0  = host.wr_blocks;
		blk0 = host.blocks;
	endtask

	task automatic check_blocks(input int n_rd, input int n_wr);
		assert (host.rd_blocks - rd0 == n_rd)
			else report_error($sformatf("read blocks %0d, expected %0d", host.rd_blocks - rd0, n_rd));
		assert (host.wr_blocks - wr0 == n_wr)
			else report_error($sformatf("write blocks %0d, expected %0d", host.wr_blocks - wr0, n_wr));
		for (int i = 0; i < n_rd + n_wr; i++)
			assert (host.lba_log[(blk0 + i) % 64] == i)
				else report_error($sformatf("block %0d had sd_lba %0d", i, host.lba_log[(blk0 + i) % 64]));
	endtask

	task automatic run_cart_download(input logic mounted, input logic ro);
		@(negedge clk_sys);
		img_mounted    = mounted;
		img_readonly   = ro;
		ioctl_index    = 8'h01;
		ioctl_download = 1'b1;
		repeat (4) @(negedge clk_sys);
		ioctl_download = 1'b0;
		repeat (3) @(negedge clk_sys);
	endtask

	task automatic pulse_req(input logic is_save);
		@(negedge clk_sys);
		if (is_save)
			save_req = 1'b1;
		else
			load_req = 1'b1;
		@(negedge clk_sys);
		save_req = 1'b0;
		load_req = 1'b0;
	endtask

	task automatic expect_no_transfer(input logic mounted, input logic ro);
		run_cart_download(mounted, ro);
		pulse_req(1'b0);
		pulse_req(1'b1);
		repeat (20) begin
			@(negedge clk_sys);
			assert (!sd_rd && !sd_wr && !sd_ack && !bk_loading)
				else report_error("SD request without backup enable");
		end
	endtask

	task automatic run_load(input logic rtc, input int n_blocks);
		int rc0;
		int wc0;
		rc0       = rtc_wr_count;
		wc0       = bk_wr_count;
		rtc_inuse = rtc;
		mark_host();
		run_cart_download(1'b1, 1'b0);
		while (!bk_loading) @(negedge clk_sys);
		while (bk_loading) @(negedge clk_sys);
		check_blocks(n_blocks, 0);
		assert (bk_wr_count - wc0 == ((int'(ram_mask) + 1) << BUF_W))
			else report_error("wrong number of bk_wr strobes");
		assert (rtc_wr_count - rc0 == (rtc ? (1 << BUF_W) : 0))
			else report_error("wrong number of bk_rtc_wr strobes");
	endtask

	////////////////////////////////////////////////////////////
	// Clock, random sources and monitors

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	initial noise = SEED;
	always @(posedge clk_sys) noise <= xorshift32(noise);

	initial bk_q = '0;
	always @(negedge clk_sys) bk_q <= noise[31:16];

	always @(posedge clk_sys) begin
		if (!reset && cheat_valid)
			valid_count <= valid_count + 1;
		if (!reset && bk_rtc_wr)
			rtc_wr_count <= rtc_wr_count + 1;
		if (!reset && bk_wr)
			bk_wr_count <= bk_wr_count + 1;
	end

	////////////////////////////////////////////////////////////
	// Assertions

	assert property (@(posedge clk_sys) disable iff (reset) !(sd_rd && sd_wr))
		else report_error("sd_rd and sd_wr high together");
	assert property (@(posedge clk_sys) disable iff (reset) bk_wr |-> sd_lba <= 32'(ram_mask))
		else report_error("bk_wr outside a data block");
	assert property (@(posedge clk_sys) disable iff (reset)
		bk_rtc_wr |-> sd_lba == 32'(ram_mask) + 32'd1)
		else report_error("bk_rtc_wr outside the clock block");
	assert property (@(posedge clk_sys) disable iff (reset)
		(bk_wr || bk_rtc_wr) |-> (bk_addr == ADDR_W'(sd_lba * (1 << BUF_W) + sd_buff_addr) &&
			bk_data == sd_buff_dout))
		else report_error("bk_addr or bk_data wrong on a buffer write");
	assert property (@(posedge clk_sys) disable iff (reset)
		sd_ack |-> sd_buff_din == expected_din(sd_lba, sd_buff_addr, bk_q, rtc_timestamp,
			rtc_savedtime))
		else report_error("sd_buff_din differs from the expected word");
	assert property (@(posedge clk_sys) disable iff (reset)
		(code_write && ioctl_addr[3:0] == 4'd14) |=> cheat_valid)
		else report_error("no cheat_valid after the offset 14 write");
	assert property (@(posedge clk_sys) disable iff (reset)
		cheat_valid |-> (cheat_flags == exp_field[0] && cheat_addr == exp_field[1] &&
			cheat_compare == exp_field[2] && cheat_replace == exp_field[3]))
		else report_error("cheat fields wrong");
	assert property (@(posedge clk_sys) disable iff (reset)
		((code_write && ioctl_addr == 25'd0) || cart_dl || pal_dl) |=> cheat_clear)
		else report_error("cheat_clear missing");

	// Run limit
	initial begin
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk_sys);
			cycles++;
		end
		$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Some tests failed");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		int vc0;
		reset            = 1'b1;
		ioctl_download   = 1'b0;
		ioctl_index      = 8'h00;
		ioctl_wr         = 1'b0;
		ioctl_addr       = '0;
		ioctl_dout       = '0;
		img_mounted      = 1'b0;
		img_readonly     = 1'b0;
		img_size_nonzero = 1'b1;
		ram_mask         = IDX_W'(3);
		rtc_inuse        = 1'b0;
		has_save         = 1'b0;
		cram_wr          = 1'b0;
		rtc_timestamp    = '0;
		rtc_savedtime    = '0;
		load_req         = 1'b0;
		save_req         = 1'b0;
		autosave_en      = 1'b0;
		osd_open         = 1'b0;
		rng              = SEED;
		for (int i = 0; i < 4; i++)
			exp_field[i] = '0;
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;

		@(negedge clk_sys);
		assert (!sd_rd && !sd_wr && !bk_loading && !save_pending && !cheat_valid && !cheat_clear)
			else report_error("outputs not idle after reset");
		end_test("reset state");

		// One code of eight words, then a short palette download
		vc0 = valid_count;
		@(negedge clk_sys);
		ioctl_index    = 8'hFF;
		ioctl_download = 1'b1;
		for (int i = 0; i < 8; i++) begin
			rng = xorshift32(rng);
			@(negedge clk_sys);
			ioctl_addr = 25'(2 * i);
			ioctl_dout = rng[15:0];
			ioctl_wr   = 1'b1;
			exp_field[i / 2][(i % 2) * 16 +: 16] = rng[15:0];
			@(negedge clk_sys);
			ioctl_wr = 1'b0;
		end
		ioctl_download = 1'b0;
		@(negedge clk_sys);
		ioctl_index    = 8'h03;
		ioctl_download = 1'b1;
		@(negedge clk_sys);
		ioctl_download = 1'b0;
		repeat (3) @(negedge clk_sys);
		assert (valid_count - vc0 == 1)
			else report_error($sformatf("%0d cheat_valid pulses, expected 1", valid_count - vc0));
		end_test("cheat assembly");

		expect_no_transfer(1'b0, 1'b0);
		expect_no_transfer(1'b1, 1'b1);
		end_test("no transfer without enable");

		run_load(1'b0, 4);
		end_test("load without clock");
		run_load(1'b1, 5);
		end_test("load with clock");

		rng           = xorshift32(rng);
		rtc_timestamp = rng;
		rng           = xorshift32(rng);
		rtc_savedtime = rng;
		mark_host();
		pulse_req(1'b1);
		while (host.wr_blocks - wr0 < 5) @(negedge clk_sys);
		repeat (4) @(negedge clk_sys);
		check_blocks(0, 5);
		assert (!sd_wr && dut.u_backup_sequencer.state == BK_IDLE)
			else report_error("save did not return to idle");
		end_test("save with clock");

		// Game writes cart RAM, then the OSD opens
		rtc_inuse = 1'b0;
		has_save  = 1'b1;
		mark_host();
		cram_wr = 1'b1;
		@(negedge clk_sys);
		cram_wr = 1'b0;
		@(negedge clk_sys);
		assert (save_pending) else report_error("save_pending not set by cram_wr");
		autosave_en = 1'b1;
		osd_open    = 1'b1;
		while (!sd_wr) @(negedge clk_sys);
		assert (!save_pending) else report_error("save_pending still set after autosave start");
		while (host.wr_blocks - wr0 < 4) @(negedge clk_sys);
		osd_open    = 1'b0;
		autosave_en = 1'b0;
		repeat (4) @(negedge clk_sys);
		check_blocks(0, 4);
		assert (!sd_wr && dut.u_backup_sequencer.state == BK_IDLE)
			else report_error("autosave did not return to idle");
		end_test("autosave");

		$display("Tests passed: %0d, failed: %0d", n_pass, n_fail);
		if (n_fail == 0 && errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// File: gb_media_ctrl.f
rtl/gb_media_pkg.sv
rtl/download_decode.sv
rtl/cheat_code_loader.sv
rtl/backup_sequencer.sv
rtl/backup_data_path.sv
rtl/gb_media_ctrl.sv
test/sd_host_model.sv
test/gb_media_ctrl_tb.sv
